/* src.f */
design/plic_pkg.sv
design/plic_gateway.sv
design/plic_target_select.sv
design/plic_regs.sv
design/plic_top.sv
bench/plic_tb.sv

/* bench/plic_tb.sv */
// drives plic_top with 32 sources and 4 contexts; stops at the first mismatch or timeout
module plic_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_SRC = 32;
    localparam int N_CTX = 4;
    localparam int N_CASES = 10;
    localparam int RD_TIMEOUT = 16;
    localparam int IP_TIMEOUT = 16;
    localparam int SEED = 97934;

    // sources used by the arbitration table, entry k of prio belongs to CASE_SRC[k]
    localparam logic [3:0][4:0] CASE_SRC = {5'd30, 5'd12, 5'd7, 5'd3};

    // context 1 owns sources 1..15, context 2 owns 16..31
    localparam logic [31:0] EN1 = 32'h0000_FFFE;
    localparam logic [31:0] EN2 = 32'hFFFF_0000;
    localparam logic [2:0]  TH1 = 3'd0;
    localparam logic [2:0]  TH2 = 3'd2;

    typedef struct packed {
        logic [1:0]      ctx;
        logic [31:0]     irq;
        logic [3:0][2:0] prio;
        logic [31:0]     enable;
        logic [2:0]      thresh;
        logic [4:0]      exp_id;
        logic            exp_ip;
    } arb_case_t;

    logic                   clk;
    logic                   nrst;
    plic_pkg::reg_req_t     req;
    logic [N_SRC-1:0]       irq;
    logic [31:0]            rdata;
    logic                   rvalid;
    logic [N_CTX-1:0]       ip;

    arb_case_t   cases [N_CASES];
    logic [2:0]  prio_model [N_SRC];

    plic_top #(
        .N_SRC(N_SRC),
        .N_CTX(N_CTX)
    ) DUT (
        .clk      (clk),
        .nrst     (nrst),
        .i_req    (req),
        .i_irq    (irq),
        .o_rdata  (rdata),
        .o_rvalid (rvalid),
        .o_ip     (ip)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] prio_addr(input int s);
        return plic_pkg::PRIORITY_BASE + 16'(s * 4);
    endfunction

    function automatic logic [15:0] enable_addr(input int c);
        return plic_pkg::ENABLE_BASE + 16'(c * 'h80);
    endfunction

    function automatic logic [15:0] thresh_addr(input int c);
        return plic_pkg::CTX_BASE + 16'(c * 'h1000) + 16'(plic_pkg::THRESHOLD_OFFSET);
    endfunction

    function automatic logic [15:0] claim_addr(input int c);
        return plic_pkg::CTX_BASE + 16'(c * 'h1000) + 16'(plic_pkg::CLAIM_OFFSET);
    endfunction

    function automatic plic_pkg::reg_req_t make_req(input logic wr, input logic [15:0] addr,
                                                    input logic [31:0] wdata);
        plic_pkg::reg_req_t r;
        r.valid = 1'b1;
        r.write = wr;
        r.addr = addr;
        r.wdata = wdata;
        return r;
    endfunction

    function automatic arb_case_t make_case(input int ctx, input logic [31:0] irq_bits,
            input int p3, input int p7, input int p12, input int p30,
            input logic [31:0] en, input int th, input int id, input logic line);
        arb_case_t tc;
        tc.ctx = 2'(ctx);
        tc.irq = irq_bits;
        tc.prio = {3'(p30), 3'(p12), 3'(p7), 3'(p3)};
        tc.enable = en;
        tc.thresh = 3'(th);
        tc.exp_id = 5'(id);
        tc.exp_ip = line;
        return tc;
    endfunction

    // try each level from the top down to just above the threshold, lowest id first
    function automatic logic [4:0] expected_winner(input logic [31:0] pend,
                                                   input logic [31:0] en, input logic [2:0] th);
        for (int p = 7; p > int'(th); p--) begin
            for (int s = 1; s < N_SRC; s++) begin
                if (pend[s] && en[s] && (prio_model[s] == 3'(p))) begin
                    return 5'(s);
                end
            end
        end
        return 5'd0;
    endfunction

    task automatic fail_run();
        $display("tests failed");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
            fail_run();
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        nrst <= 1'b0;
        req <= '0;
        irq <= '0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
        @(posedge clk);
        req <= make_req(1'b1, addr, data);
        @(posedge clk);
        req <= '0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
        int waited;
        @(posedge clk);
        req <= make_req(1'b0, addr, '0);
        @(posedge clk);
        req <= '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!rvalid && waited < RD_TIMEOUT);
        if (!rvalid) begin
            $display("read data for address 0x%0h did not arrive within %0d cycles",
                     addr, RD_TIMEOUT);
            fail_run();
        end
        data = rdata;
    endtask

    task automatic wait_ip(input logic [N_CTX-1:0] expected);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ip !== expected && waited < IP_TIMEOUT);
        if (ip !== expected) begin
            $display("interrupt lines did not reach %b within %0d cycles, still %b",
                     expected, IP_TIMEOUT, ip);
            fail_run();
        end
    endtask

    task automatic load_cases();
        cases[0] = make_case(0, 32'h0000_0008, 3, 0, 0, 0, 32'hFFFF_FFFF, 0, 3, 1'b1);
        cases[1] = make_case(1, 32'h4000_1088, 2, 5, 5, 1, 32'hFFFF_FFFF, 0, 7, 1'b1);
        cases[2] = make_case(2, 32'h4000_1088, 2, 5, 5, 1, 32'hFFFF_FF7F, 0, 12, 1'b1);
        cases[3] = make_case(3, 32'h4000_1088, 2, 5, 5, 6, 32'hFFFF_FFFF, 5, 30, 1'b1);
        cases[4] = make_case(0, 32'h4000_1088, 2, 5, 5, 6, 32'hFFFF_FFFF, 6, 0, 1'b0);
        // source 7 is requested but has priority 0
        cases[5] = make_case(1, 32'h4000_0080, 7, 0, 4, 3, 32'hFFFF_FFFF, 0, 30, 1'b1);
        cases[6] = make_case(2, 32'h0000_1008, 4, 4, 4, 4, 32'h4000_1000, 0, 12, 1'b1);
        cases[7] = make_case(3, 32'h0000_0001, 7, 7, 7, 7, 32'hFFFF_FFFF, 0, 0, 1'b0);
        cases[8] = make_case(0, 32'h4000_1088, 1, 1, 1, 1, 32'hFFFF_FFFF, 1, 0, 1'b0);
        cases[9] = make_case(1, 32'h4000_1000, 0, 0, 7, 7, 32'hFFFF_FFFF, 6, 12, 1'b1);
    endtask

    task automatic inspect_reset_state();
        logic [31:0] rd;
        @(negedge clk);
        check(32'(ip), 32'h0, "interrupt lines after reset");
        bus_read(prio_addr(5), rd);
        check(rd, 32'h0, "priority after reset");
        bus_read(enable_addr(0), rd);
        check(rd, 32'h0, "enable after reset");
        bus_read(thresh_addr(2), rd);
        check(rd, 32'h0, "threshold after reset");
        bus_read(plic_pkg::PENDING_BASE, rd);
        check(rd, 32'h0, "pending after reset");
    endtask

    task automatic register_readback();
        logic [31:0] rd;
        bus_write(prio_addr(5), 32'hFFFF_FFFD);
        bus_read(prio_addr(5), rd);
        check(rd, 32'hFFFF_FFFD & 32'h7, "priority 5 readback");
        bus_write(prio_addr(31), 32'h2);
        bus_read(prio_addr(31), rd);
        check(rd, 32'h2, "priority 31 readback");
        // source 0 is reserved
        bus_write(prio_addr(0), 32'h7);
        bus_read(prio_addr(0), rd);
        check(rd, 32'h0, "priority 0 readback");
        bus_write(enable_addr(1), 32'hDEAD_BEEF);
        bus_read(enable_addr(1), rd);
        check(rd, 32'hDEAD_BEEF & ~32'h1, "enable 1 readback");
        bus_write(thresh_addr(3), 32'h1E);
        bus_read(thresh_addr(3), rd);
        check(rd, 32'h1E & 32'h7, "threshold 3 readback");
        bus_write(enable_addr(5), 32'hFFFF);
        bus_read(enable_addr(5), rd);
        check(rd, 32'h0, "enable of missing context 5");
        bus_write(thresh_addr(6), 32'h3);
        bus_read(thresh_addr(6), rd);
        check(rd, 32'h0, "threshold of missing context 6");
    endtask

    task automatic run_case(input int idx, input arb_case_t tc);
        logic [31:0]      rd;
        logic [31:0]      exp_pend;
        logic [N_CTX-1:0] exp_line;
        reset_dut();
        exp_pend = '0;
        for (int k = 0; k < 4; k++) begin
            bus_write(prio_addr(CASE_SRC[k]), 32'(tc.prio[k]));
            // only requested sources with a nonzero priority pend
            if (tc.irq[CASE_SRC[k]] && tc.prio[k] != 3'd0) begin
                exp_pend[CASE_SRC[k]] = 1'b1;
            end
        end
        bus_write(enable_addr(tc.ctx), tc.enable);
        bus_write(thresh_addr(tc.ctx), 32'(tc.thresh));
        @(posedge clk);
        irq <= tc.irq;
        bus_read(plic_pkg::PENDING_BASE, rd);
        check(rd, exp_pend, $sformatf("case %0d pending word", idx));
        exp_line = '0;
        exp_line[tc.ctx] = tc.exp_ip;
        wait_ip(exp_line);
        bus_read(claim_addr(tc.ctx), rd);
        check(rd, 32'(tc.exp_id), $sformatf("case %0d claim id", idx));
    endtask

    task automatic claim_complete_flow();
        logic [31:0] rd;
        reset_dut();
        bus_write(prio_addr(9), 32'h4);
        bus_write(enable_addr(0), 32'h1 << 9);
        @(posedge clk);
        irq <= 32'h1 << 9;
        wait_ip(4'b0001);
        bus_read(claim_addr(0), rd);
        check(rd, 32'd9, "claim of source 9");
        wait_ip(4'b0000);
        // request is still high but the source is in service
        for (int k = 0; k < 3; k++) begin
            bus_read(plic_pkg::PENDING_BASE, rd);
            check(rd, 32'h0, "pending while in service");
        end
        bus_write(claim_addr(0), 32'd9);
        bus_read(plic_pkg::PENDING_BASE, rd);
        check(rd, 32'h1 << 9, "pending after complete");
        wait_ip(4'b0001);
    endtask

    task automatic context_isolation();
        logic [31:0]      rd;
        logic [31:0]      req_bits;
        logic [31:0]      pend_model;
        logic [4:0]       w1;
        logic [4:0]       w2;
        logic [4:0]       win;
        logic [N_CTX-1:0] line;
        int               ctx;
        int               steps;
        logic             done;
        reset_dut();
        prio_model[0] = 3'd0;
        for (int s = 1; s < N_SRC; s++) begin
            prio_model[s] = 3'($urandom_range(7, 1));
            bus_write(prio_addr(s), 32'(prio_model[s]));
        end
        bus_write(enable_addr(1), EN1);
        bus_write(enable_addr(2), EN2);
        bus_write(thresh_addr(1), 32'(TH1));
        bus_write(thresh_addr(2), 32'(TH2));
        pend_model = '0;
        for (int it = 0; it < 4; it++) begin
            // first round requests only sources of context 1
            req_bits = $urandom() & ((it == 0) ? EN1 : 32'hFFFF_FFFE);
            @(posedge clk);
            irq <= req_bits;
            pend_model = pend_model | req_bits;
            bus_read(plic_pkg::PENDING_BASE, rd);
            check(rd, pend_model, $sformatf("round %0d pending word", it));
            @(posedge clk);
            irq <= '0;
            steps = 0;
            done = 1'b0;
            while (!done) begin
                w1 = expected_winner(pend_model, EN1, TH1);
                w2 = expected_winner(pend_model, EN2, TH2);
                line = '0;
                line[1] = (w1 != 5'd0);
                line[2] = (w2 != 5'd0);
                wait_ip(line);
                if (w1 == 5'd0 && w2 == 5'd0) begin
                    done = 1'b1;
                end else begin
                    ctx = (w1 != 5'd0) ? 1 : 2;
                    win = (w1 != 5'd0) ? w1 : w2;
                    bus_read(claim_addr(ctx), rd);
                    check(rd, 32'(win), $sformatf("round %0d claim on context %0d", it, ctx));
                    pend_model[win] = 1'b0;
                    bus_write(claim_addr(ctx), 32'(win));
                    steps++;
                    if (steps > N_SRC) begin
                        $display("claim sequence did not drain within %0d claims", N_SRC);
                        fail_run();
                    end
                end
            end
            bus_read(plic_pkg::PENDING_BASE, rd);
            check(rd, pend_model, $sformatf("round %0d pending after claims", it));
        end
    endtask

    initial begin
        int unsigned seed_val;
        req = '0;
        irq = '0;
        nrst = 1'b0;
        seed_val = $urandom(SEED);
        load_cases();
        reset_dut();
        inspect_reset_state();
        register_readback();
        for (int i = 0; i < N_CASES; i++) begin
            run_case(i, cases[i]);
        end
        claim_complete_flow();
        context_isolation();
        $display("all tests passed");
        $finish;
    end

endmodule

/* design/plic_top.sv */
// N_SRC from 2 to 32 and N_CTX from 1 to 8; i_irq[0] is ignored
module plic_top #(
    parameter int N_SRC = 32,
    parameter int N_CTX = 4
) (
    input  logic                              clk,
    input  logic                              nrst,
    input  plic_pkg::reg_req_t                i_req,
    input  logic [N_SRC-1:0]                  i_irq,
    output logic [plic_pkg::DATA_BITS-1:0]    o_rdata,
    output logic                              o_rvalid,
    output logic [N_CTX-1:0]                  o_ip
);

    logic [N_SRC*plic_pkg::PRIO_BITS-1:0] src_prio;
    logic [N_CTX*N_SRC-1:0]               enable;
    logic [N_CTX*plic_pkg::PRIO_BITS-1:0] threshold;
    logic [N_SRC-1:0]                     pending;
    logic [N_CTX*plic_pkg::ID_BITS-1:0]   best_id;
    logic [N_CTX-1:0]                     ip;

    logic                         claim;
    logic [plic_pkg::ID_BITS-1:0] claim_id;
    logic                         complete;
    logic [plic_pkg::ID_BITS-1:0] complete_id;

    plic_regs #(
        .N_SRC(N_SRC),
        .N_CTX(N_CTX)
    ) u_regs (
        .clk           (clk),
        .nrst          (nrst),
        .i_req         (i_req),
        .i_pending     (pending),
        .i_best_id     (best_id),
        .i_ip          (ip),
        .o_rdata       (o_rdata),
        .o_rvalid      (o_rvalid),
        .o_src_prio    (src_prio),
        .o_enable      (enable),
        .o_threshold   (threshold),
        .o_claim       (claim),
        .o_claim_id    (claim_id),
        .o_complete    (complete),
        .o_complete_id (complete_id)
    );

    plic_gateway #(
        .N_SRC(N_SRC)
    ) u_gateway (
        .clk           (clk),
        .nrst          (nrst),
        .i_irq         (i_irq),
        .i_src_prio    (src_prio),
        .i_claim       (claim),
        .i_claim_id    (claim_id),
        .i_complete    (complete),
        .i_complete_id (complete_id),
        .o_pending     (pending)
    );

    plic_target_select #(
        .N_SRC(N_SRC),
        .N_CTX(N_CTX)
    ) u_target_select (
        .clk         (clk),
        .nrst        (nrst),
        .i_pending   (pending),
        .i_src_prio  (src_prio),
        .i_enable    (enable),
        .i_threshold (threshold),
        .o_best_id   (best_id),
        .o_ip        (ip)
    );

    assign o_ip = ip;

endmodule

/* design/plic_regs.sv */
// word access only; misdecoded or out-of-range addresses read zero and ignore writes
module plic_regs #(
    parameter int N_SRC = 32,
    parameter int N_CTX = 4
) (
    input  logic                                         clk,
    input  logic                                         nrst,
    input  plic_pkg::reg_req_t                           i_req,
    input  logic [N_SRC-1:0]                             i_pending,
    input  logic [N_CTX*plic_pkg::ID_BITS-1:0]           i_best_id,
    input  logic [N_CTX-1:0]                             i_ip,
    output logic [plic_pkg::DATA_BITS-1:0]               o_rdata,
    output logic                                         o_rvalid,
    output logic [N_SRC*plic_pkg::PRIO_BITS-1:0]         o_src_prio,
    output logic [N_CTX*N_SRC-1:0]                       o_enable,
    output logic [N_CTX*plic_pkg::PRIO_BITS-1:0]         o_threshold,
    output logic                                         o_claim,
    output logic [plic_pkg::ID_BITS-1:0]                 o_claim_id,
    output logic                                         o_complete,
    output logic [plic_pkg::ID_BITS-1:0]                 o_complete_id
);

    // result of the address decode
    typedef struct packed {
        plic_pkg::reg_region_e        region;
        logic [plic_pkg::ID_BITS-1:0] src;
        logic [2:0]                   ctx;
    } reg_dec_t;

    reg_dec_t dec;

    logic [N_SRC*plic_pkg::PRIO_BITS-1:0] src_prio_q;
    logic [N_CTX*N_SRC-1:0]               enable_q;
    logic [N_CTX*plic_pkg::PRIO_BITS-1:0] thresh_q;

    logic [plic_pkg::DATA_BITS-1:0] rdata_d;
    logic [plic_pkg::DATA_BITS-1:0] rdata_q;
    logic                           rvalid_q;

    logic                           sel_ip;
    logic [plic_pkg::ID_BITS-1:0]   sel_best_id;

    logic rd_strobe;
    logic wr_strobe;

    assign rd_strobe = i_req.valid && !i_req.write;
    assign wr_strobe = i_req.valid && i_req.write;

    // addr[1:0] is ignored everywhere
    always_comb begin
        logic [plic_pkg::ADDR_BITS-1:0] a;

        a = i_req.addr;
        dec.region = plic_pkg::REG_NONE;
        dec.src = a[2 +: plic_pkg::ID_BITS];
        dec.ctx = '0;

        if (a[15:12] == plic_pkg::PRIORITY_BASE[15:12]) begin
            // source 0 is reserved
            if ((a[11:2] != '0) && (a[11:2] < N_SRC)) begin
                dec.region = plic_pkg::REG_PRIORITY;
            end
        end else if (a[15:2] == plic_pkg::PENDING_BASE[15:2]) begin
            dec.region = plic_pkg::REG_PENDING;
        end else if (a[15:12] == plic_pkg::ENABLE_BASE[15:12]) begin
            // one word per context, 0x80 apart
            if ((a[6:2] == '0) && (a[11:7] < N_CTX)) begin
                dec.region = plic_pkg::REG_ENABLE;
                dec.ctx = a[9:7];
            end
        end else if (a[15] == plic_pkg::CTX_BASE[15]) begin
            if (a[14:12] < N_CTX) begin
                dec.ctx = a[14:12];
                if (a[11:2] == plic_pkg::THRESHOLD_OFFSET[11:2]) begin
                    dec.region = plic_pkg::REG_THRESHOLD;
                end else if (a[11:2] == plic_pkg::CLAIM_OFFSET[11:2]) begin
                    dec.region = plic_pkg::REG_CLAIM;
                end
            end
        end
    end

    // line and best id of the addressed context
    always_comb begin
        sel_ip = 1'b0;
        sel_best_id = '0;
        for (int c = 0; c < N_CTX; c++) begin
            if (dec.ctx == 3'(c)) begin
                sel_ip = i_ip[c];
                sel_best_id = i_best_id[c*plic_pkg::ID_BITS +: plic_pkg::ID_BITS];
            end
        end
    end

    // configuration storage
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            src_prio_q <= '0;
            enable_q <= '0;
            thresh_q <= '0;
        end else if (wr_strobe) begin
            case (dec.region)
                plic_pkg::REG_PRIORITY: begin
                    src_prio_q[dec.src*plic_pkg::PRIO_BITS +: plic_pkg::PRIO_BITS]
                        <= i_req.wdata[plic_pkg::PRIO_BITS-1:0];
                end
                plic_pkg::REG_ENABLE: begin
                    // source 0 can never be enabled
                    enable_q[dec.ctx*N_SRC +: N_SRC] <= {i_req.wdata[N_SRC-1:1], 1'b0};
                end
                plic_pkg::REG_THRESHOLD: begin
                    thresh_q[dec.ctx*plic_pkg::PRIO_BITS +: plic_pkg::PRIO_BITS]
                        <= i_req.wdata[plic_pkg::PRIO_BITS-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // read mux, sampled at the strobe edge
    always_comb begin
        rdata_d = '0;
        case (dec.region)
            plic_pkg::REG_PRIORITY: begin
                rdata_d[plic_pkg::PRIO_BITS-1:0] =
                    src_prio_q[dec.src*plic_pkg::PRIO_BITS +: plic_pkg::PRIO_BITS];
            end
            plic_pkg::REG_PENDING: begin
                rdata_d[N_SRC-1:0] = i_pending;
            end
            plic_pkg::REG_ENABLE: begin
                rdata_d[N_SRC-1:0] = enable_q[dec.ctx*N_SRC +: N_SRC];
            end
            plic_pkg::REG_THRESHOLD: begin
                rdata_d[plic_pkg::PRIO_BITS-1:0] =
                    thresh_q[dec.ctx*plic_pkg::PRIO_BITS +: plic_pkg::PRIO_BITS];
            end
            plic_pkg::REG_CLAIM: begin
                // nothing to claim when the line is low
                if (sel_ip) begin
                    rdata_d[plic_pkg::ID_BITS-1:0] = sel_best_id;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rdata_q <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_strobe;
            if (rd_strobe) begin
                rdata_q <= rdata_d;
            end
        end
    end

    // claim and complete act on the gateway at the strobe edge
    assign o_claim = rd_strobe && (dec.region == plic_pkg::REG_CLAIM) && sel_ip;
    assign o_claim_id = sel_best_id;
    assign o_complete = wr_strobe && (dec.region == plic_pkg::REG_CLAIM);
    assign o_complete_id = i_req.wdata[plic_pkg::ID_BITS-1:0];

    assign o_rdata = rdata_q;
    assign o_rvalid = rvalid_q;
    assign o_src_prio = src_prio_q;
    assign o_enable = enable_q;
    assign o_threshold = thresh_q;

endmodule

/* design/plic_target_select.sv */
// one registered stage; ties go to the lowest source number and source 0 never wins
module plic_target_select #(
    parameter int N_SRC = 32,
    parameter int N_CTX = 4
) (
    input  logic                                         clk,
    input  logic                                         nrst,
    input  logic [N_SRC-1:0]                             i_pending,
    input  logic [N_SRC*plic_pkg::PRIO_BITS-1:0]         i_src_prio,
    input  logic [N_CTX*N_SRC-1:0]                       i_enable,
    input  logic [N_CTX*plic_pkg::PRIO_BITS-1:0]         i_threshold,
    output logic [N_CTX*plic_pkg::ID_BITS-1:0]           o_best_id,
    output logic [N_CTX-1:0]                             o_ip
);

    logic [N_CTX*plic_pkg::ID_BITS-1:0] best_id_d;
    logic [N_CTX*plic_pkg::ID_BITS-1:0] best_id_q;
    logic [N_CTX-1:0]                   ip_d;
    logic [N_CTX-1:0]                   ip_q;

    // full scan of all sources for every context
    always_comb begin
        logic [plic_pkg::PRIO_BITS-1:0] best_prio;
        logic [plic_pkg::PRIO_BITS-1:0] thresh;
        logic [plic_pkg::PRIO_BITS-1:0] prio;
        logic [plic_pkg::ID_BITS-1:0]   best_id;

        best_id_d = '0;
        ip_d = '0;

        for (int c = 0; c < N_CTX; c++) begin
            best_prio = '0;
            best_id = '0;
            thresh = i_threshold[c*plic_pkg::PRIO_BITS +: plic_pkg::PRIO_BITS];

            for (int s = 1; s < N_SRC; s++) begin
                prio = i_src_prio[s*plic_pkg::PRIO_BITS +: plic_pkg::PRIO_BITS];
                // strict compare keeps the earlier (lower) id on a tie
                if (i_pending[s] && i_enable[c*N_SRC + s]
                        && (prio > thresh) && (prio > best_prio)) begin
                    best_prio = prio;
                    best_id = plic_pkg::ID_BITS'(s);
                end
            end

            best_id_d[c*plic_pkg::ID_BITS +: plic_pkg::ID_BITS] = best_id;
            ip_d[c] = |best_id;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            best_id_q <= '0;
            ip_q <= '0;
        end else begin
            best_id_q <= best_id_d;
            ip_q <= ip_d;
        end
    end

    assign o_best_id = best_id_q;
    assign o_ip = ip_q;

endmodule

/* design/plic_gateway.sv */
// level requests only; pending is sticky until claimed and source 0 never pends
module plic_gateway #(
    parameter int N_SRC = 32
) (
    input  logic                                   clk,
    input  logic                                   nrst,
    input  logic [N_SRC-1:0]                       i_irq,
    input  logic [N_SRC*plic_pkg::PRIO_BITS-1:0]   i_src_prio,
    input  logic                                   i_claim,
    input  logic [plic_pkg::ID_BITS-1:0]           i_claim_id,
    input  logic                                   i_complete,
    input  logic [plic_pkg::ID_BITS-1:0]           i_complete_id,
    output logic [N_SRC-1:0]                       o_pending
);

    logic [N_SRC-1:0] pending_q;
    logic [N_SRC-1:0] pending_d;
    logic [N_SRC-1:0] in_service_q;
    logic [N_SRC-1:0] in_service_d;

    always_comb begin
        pending_d = pending_q;
        in_service_d = in_service_q;

        for (int s = 1; s < N_SRC; s++) begin
            // a source in service is held off until software completes it
            if (i_irq[s] && (i_src_prio[s*plic_pkg::PRIO_BITS +: plic_pkg::PRIO_BITS] != '0)
                    && !in_service_q[s]) begin
                pending_d[s] = 1'b1;
            end

            // claim wins over a new request on the same edge
            if (i_claim && (i_claim_id == plic_pkg::ID_BITS'(s))) begin
                pending_d[s] = 1'b0;
                in_service_d[s] = 1'b1;
            end

            if (i_complete && (i_complete_id == plic_pkg::ID_BITS'(s))) begin
                in_service_d[s] = 1'b0;
            end
        end

        // reserved source
        pending_d[0] = 1'b0;
        in_service_d[0] = 1'b0;
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pending_q <= '0;
            in_service_q <= '0;
        end else begin
            pending_q <= pending_d;
            in_service_q <= in_service_d;
        end
    end

    assign o_pending = pending_q;

endmodule

/* design/plic_pkg.sv */
// assumes at most 32 sources (source 0 reserved), at most 8 contexts and full-word register access
package plic_pkg;

    // priority and threshold width, a priority of 0 disables the source
    localparam int PRIO_BITS = 3;

    // source number width
    localparam int ID_BITS = 5;

    localparam int ADDR_BITS = 16;
    localparam int DATA_BITS = 32;

    // one register access, valid is a single-cycle strobe
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] wdata;
    } reg_req_t;

    // decoded register region of an address
    typedef enum logic [2:0] {
        REG_PRIORITY,
        REG_PENDING,
        REG_ENABLE,
        REG_THRESHOLD,
        REG_CLAIM,
        REG_NONE
    } reg_region_e;

    // source i priority at PRIORITY_BASE + 4*i
    localparam logic [ADDR_BITS-1:0] PRIORITY_BASE = 16'h0000;

    // single pending word
    localparam logic [ADDR_BITS-1:0] PENDING_BASE = 16'h1000;

    // context c enable word at ENABLE_BASE + 0x80*c
    localparam logic [ADDR_BITS-1:0] ENABLE_BASE = 16'h2000;

    // context c block at CTX_BASE + 0x1000*c
    localparam logic [ADDR_BITS-1:0] CTX_BASE = 16'h8000;

    // offsets inside a context block
    localparam logic [11:0] THRESHOLD_OFFSET = 12'h000;
    localparam logic [11:0] CLAIM_OFFSET = 12'h004;

endpackage
